/* build.f */
sdram_pkg.sv
sdram_refresh_timer.sv
sdram_init_seq.sv
sdram_access_fsm.sv
sdram_ctrl.sv
sdram_model.sv
sdram_ctrl_checker.sv
tb_sdram_ctrl.sv

/* run.sh */
#!/bin/sh
# build and run the sdram controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_sdram_ctrl \
    -f build.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

/* sdram_access_fsm.sv */
// sdram access state machine
// passes the init sequence to the pins, then arbitrates refresh, read
// and write in idle and runs single-row bursts ended by bst and precharge

`timescale 1ns/10ps

module sdram_access_fsm (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  sdram_pkg::sdram_bus_t i_init_bus,
    input  logic                  i_init_done,
    input  logic                  i_ref_req,
    output logic                  o_ref_ack,
    input  sdram_pkg::mem_req_t   i_req,
    input  logic                  i_rd_strobe,
    input  logic                  i_wr_strobe,
    output logic                  o_ready,
    input  sdram_pkg::data_t      i_wr_data,
    output logic                  o_wr_data_req,
    input  sdram_pkg::data_t      i_dq,
    output sdram_pkg::data_t      o_rd_data,
    output logic                  o_rd_valid,
    output sdram_pkg::sdram_bus_t o_bus
);
    import sdram_pkg::*;

    typedef enum logic [3:0] {
        S_INIT,
        S_IDLE,
        S_RCD,
        S_WR,
        S_WR_DATA,
        S_WR_END,
        S_RD,
        S_RD_DATA,
        S_PRE,
        S_REF,
        S_WAIT
    } acc_state_e;

    acc_state_e        state;
    acc_state_e        wait_next;
    logic [WAIT_W-1:0] wait_cnt;

    sdram_addr_t       req_addr;   // latched in idle
    logic [LEN_W-1:0]  rem;        // words still to move
    logic              is_write;

    assign o_ready = (state == S_IDLE);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            state         <= S_INIT;
            wait_next     <= S_IDLE;
            wait_cnt      <= '0;
            rem           <= '0;
            is_write      <= 1'b0;
            o_ref_ack     <= 1'b0;
            o_wr_data_req <= 1'b0;
            o_rd_valid    <= 1'b0;
            o_bus         <= BUS_NOP;
        end
        else
        begin
            // defaults, nop on the pins and no strobes
            o_bus.cmd   <= NOP;
            o_bus.dq_oe <= 1'b0;
            o_ref_ack   <= 1'b0;
            o_rd_valid  <= 1'b0;

            case (state)
                S_INIT:
                begin
                    if (!i_init_done)
                        o_bus <= i_init_bus;
                    else
                        state <= S_IDLE;
                end

                // arbitration ---------------------------
                S_IDLE:
                begin
                    if (i_ref_req)                    // refresh first, strobe dropped
                    begin
                        o_bus.cmd  <= PRE;
                        o_bus.addr <= PRE_ALL_ADDR;
                        wait_cnt   <= WAIT_W'(T_RP - 2);
                        wait_next  <= S_REF;
                        state      <= S_WAIT;
                    end
                    else if (i_rd_strobe || i_wr_strobe)
                    begin
                        req_addr   <= i_req.addr;
                        rem        <= (i_req.len == '0) ? LEN_W'(1) : i_req.len;
                        is_write   <= ~i_rd_strobe;   // read wins a tie
                        o_bus.cmd  <= ACT;
                        o_bus.ba   <= i_req.addr.bank;
                        o_bus.addr <= i_req.addr.row;
                        wait_cnt   <= WAIT_W'(T_RCD - 2);
                        state      <= S_RCD;
                    end
                end

                S_RCD:
                begin
                    if (wait_cnt == '0)
                    begin
                        o_wr_data_req <= is_write;    // word 0 sampled next cycle
                        state         <= is_write ? S_WR : S_RD;
                    end
                    else
                    begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end

                // write burst ---------------------------
                S_WR, S_WR_DATA:
                begin
                    o_bus.cmd   <= (state == S_WR) ? WRITE : NOP;
                    o_bus.ba    <= req_addr.bank;
                    o_bus.addr  <= ROW_W'(req_addr.col);   // a10 low, no auto precharge
                    o_bus.dq    <= i_wr_data;
                    o_bus.dq_oe <= 1'b1;
                    rem         <= rem - 1'b1;
                    if (rem == LEN_W'(1))
                    begin
                        o_wr_data_req <= 1'b0;
                        state         <= S_WR_END;
                    end
                    else
                    begin
                        state <= S_WR_DATA;
                    end
                end

                S_WR_END:
                begin
                    o_bus.cmd <= BST;
                    wait_cnt  <= WAIT_W'(1);   // two nops before precharge
                    wait_next <= S_PRE;
                    state     <= S_WAIT;
                end

                // read burst ----------------------------
                S_RD:
                begin
                    o_bus.cmd  <= READ;
                    o_bus.ba   <= req_addr.bank;
                    o_bus.addr <= ROW_W'(req_addr.col);
                    wait_cnt   <= WAIT_W'(CAS_LAT - 1);
                    wait_next  <= S_RD_DATA;
                    state      <= S_WAIT;
                end

                S_RD_DATA:
                begin
                    o_rd_data  <= i_dq;
                    o_rd_valid <= 1'b1;
                    rem        <= rem - 1'b1;
                    if (rem == LEN_W'(1))
                    begin
                        o_bus.cmd <= BST;   // goes out with the last word
                        state     <= S_PRE;
                    end
                end

                // precharge and refresh -----------------
                S_PRE:
                begin
                    o_bus.cmd  <= PRE;
                    o_bus.addr <= PRE_ALL_ADDR;
                    wait_cnt   <= WAIT_W'(T_RP - 2);
                    wait_next  <= S_IDLE;
                    state      <= S_WAIT;
                end

                S_REF:
                begin
                    o_bus.cmd <= REF;
                    o_ref_ack <= 1'b1;
                    wait_cnt  <= WAIT_W'(T_RC - 2);
                    wait_next <= S_IDLE;
                    state     <= S_WAIT;
                end

                S_WAIT:
                begin
                    if (wait_cnt == '0)
                        state <= wait_next;
                    else
                        wait_cnt <= wait_cnt - 1'b1;
                end

                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

/* sdram_ctrl.sv */
// sdram controller top level
// init sequencer, refresh timer and access fsm behind one user port
// and one registered pin bus

`timescale 1ns/10ps

module sdram_ctrl (
    input  logic                  i_clk,
    input  logic                  i_rst,
    // user side
    input  sdram_pkg::mem_req_t   i_req,
    input  logic                  i_rd_strobe,
    input  logic                  i_wr_strobe,
    output logic                  o_ready,
    output logic                  o_wr_data_req,
    input  sdram_pkg::data_t      i_wr_data,
    output logic                  o_rd_valid,
    output sdram_pkg::data_t      o_rd_data,
    // device side
    output sdram_pkg::sdram_bus_t o_bus,
    input  sdram_pkg::data_t      i_dq
);
    import sdram_pkg::*;

    sdram_bus_t init_bus;
    logic       init_done;
    logic       ref_req;
    logic       ref_ack;

    sdram_refresh_timer u_refresh (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_enable  (init_done),   // no refresh before the mode register is set
        .i_ref_ack (ref_ack),
        .o_ref_req (ref_req)
    );

    sdram_init_seq u_init (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .o_bus       (init_bus),
        .o_init_done (init_done)
    );

    sdram_access_fsm u_access (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_init_bus    (init_bus),
        .i_init_done   (init_done),
        .i_ref_req     (ref_req),
        .o_ref_ack     (ref_ack),
        .i_req         (i_req),
        .i_rd_strobe   (i_rd_strobe),
        .i_wr_strobe   (i_wr_strobe),
        .o_ready       (o_ready),
        .i_wr_data     (i_wr_data),
        .o_wr_data_req (o_wr_data_req),
        .i_dq          (i_dq),
        .o_rd_data     (o_rd_data),
        .o_rd_valid    (o_rd_valid),
        .o_bus         (o_bus)
    );

endmodule

/* sdram_ctrl_checker.sv */
// protocol checks on the sdram pin bus
// tracks open rows per bank and flags illegal command sequences

`timescale 1ns/10ps

module sdram_ctrl_checker (
    input logic                  i_clk,
    input logic                  i_rst,
    input sdram_pkg::sdram_bus_t i_bus,
    input logic                  i_ready,
    input logic                  i_rd_valid,
    input logic                  i_wr_data_req
);
    import sdram_pkg::*;

    logic [(1 << BANK_W)-1:0] bank_open;
    int                       fail_count = 0;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            bank_open <= '0;
        else if (i_bus.cmd == ACT)
            bank_open[i_bus.ba] <= 1'b1;
        else if (i_bus.cmd == PRE)
        begin
            if (i_bus.addr[10])
                bank_open <= '0;   // precharge all
            else
                bank_open[i_bus.ba] <= 1'b0;
        end
    end

    a_rw_open_row: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_bus.cmd == READ || i_bus.cmd == WRITE) |-> bank_open[i_bus.ba])
    else
    begin
        $error("read or write to bank %0d with no open row", i_bus.ba);
        fail_count++;
    end

    a_act_not_ready: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_bus.cmd == ACT) |-> !i_ready)
    else
    begin
        $error("activate issued while ready is high");
        fail_count++;
    end

    a_rd_wr_apart: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_rd_valid && i_wr_data_req))
    else
    begin
        $error("read valid and write data request high together");
        fail_count++;
    end

endmodule

/* sdram_init_seq.sv */
// sdram power-up initialisation
// power-up wait, precharge all, two auto refreshes and mode register set,
// then holds o_init_done high

`timescale 1ns/10ps

module sdram_init_seq (
    input  logic                  i_clk,
    input  logic                  i_rst,
    output sdram_pkg::sdram_bus_t o_bus,
    output logic                  o_init_done
);
    import sdram_pkg::*;

    typedef enum logic [2:0] {
        S_WAIT,
        S_PRE,
        S_REF1,
        S_REF2,
        S_MRS,
        S_DONE
    } init_state_e;

    init_state_e       state;
    init_state_e       wait_next;   // where S_WAIT goes when the count runs out
    logic [WAIT_W-1:0] wait_cnt;

    // a wait load of n gives n+1 nop cycles after the command
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            state       <= S_WAIT;
            wait_next   <= S_PRE;
            wait_cnt    <= WAIT_W'(POWERUP_CYCLES - 1);
            o_bus       <= BUS_NOP;
            o_init_done <= 1'b0;
        end
        else
        begin
            o_bus <= BUS_NOP;

            case (state)
                S_WAIT:
                begin
                    if (wait_cnt == '0)
                        state <= wait_next;
                    else
                        wait_cnt <= wait_cnt - 1'b1;
                end

                S_PRE:
                begin
                    o_bus.cmd  <= PRE;
                    o_bus.addr <= PRE_ALL_ADDR;
                    wait_cnt   <= WAIT_W'(T_RP - 2);
                    wait_next  <= S_REF1;
                    state      <= S_WAIT;
                end

                S_REF1:
                begin
                    o_bus.cmd <= REF;
                    wait_cnt  <= WAIT_W'(T_RC - 2);
                    wait_next <= S_REF2;
                    state     <= S_WAIT;
                end

                S_REF2:
                begin
                    o_bus.cmd <= REF;
                    wait_cnt  <= WAIT_W'(T_RC - 2);
                    wait_next <= S_MRS;
                    state     <= S_WAIT;
                end

                S_MRS:
                begin
                    o_bus.cmd  <= MRS;
                    o_bus.ba   <= '0;
                    o_bus.addr <= MODE_WORD;
                    wait_cnt   <= WAIT_W'(T_MRD - 2);
                    wait_next  <= S_DONE;
                    state      <= S_WAIT;
                end

                S_DONE:
                begin
                    o_init_done <= 1'b1;   // stays here until reset
                end

                default:
                begin
                    state <= S_PRE;
                end
            endcase
        end
    end

endmodule

/* sdram_model.sv */
// behavioural sdram for the testbench
// decodes pin commands, keeps an open row per bank and stores words,
// read data comes back on dq after the cas latency

`timescale 1ns/10ps

module sdram_model (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  sdram_pkg::sdram_bus_t i_bus,
    output sdram_pkg::data_t      o_dq
);
    import sdram_pkg::*;

    data_t             mem [logic [23:0]];   // sparse, keyed by bank row col
    logic [ROW_W-1:0]  open_row [1 << BANK_W];
    logic              wr_active;
    logic              rd_active;
    logic [BANK_W-1:0] cur_bank;
    logic [COL_W-1:0]  cur_col;
    int                rd_wait;

    function automatic data_t read_word(input logic [23:0] k);
        if (mem.exists(k))
            return mem[k];
        return '0;
    endfunction

    always @(posedge i_clk)
    begin
        if (i_rst)
        begin
            wr_active <= 1'b0;
            rd_active <= 1'b0;
            rd_wait   <= 0;
            o_dq      <= '0;
        end
        else
        begin
            // data phase of a burst already running
            if (rd_active)
            begin
                if (rd_wait != 0)
                begin
                    rd_wait <= rd_wait - 1;
                end
                else
                begin
                    o_dq    <= read_word({cur_bank, open_row[cur_bank], cur_col});
                    cur_col <= cur_col + 1'b1;   // wraps inside the page
                end
            end
            if (wr_active && i_bus.dq_oe && i_bus.cmd == NOP)
            begin
                mem[{cur_bank, open_row[cur_bank], cur_col}] = i_bus.dq;
                cur_col <= cur_col + 1'b1;
            end

            if (!i_bus.cmd[3])   // chip select low
            begin
                case (i_bus.cmd)
                    ACT:
                    begin
                        open_row[i_bus.ba] <= i_bus.addr;
                    end
                    WRITE:
                    begin
                        wr_active <= 1'b1;
                        rd_active <= 1'b0;
                        cur_bank  <= i_bus.ba;
                        mem[{i_bus.ba, open_row[i_bus.ba], i_bus.addr[COL_W-1:0]}] = i_bus.dq;
                        cur_col   <= i_bus.addr[COL_W-1:0] + 1'b1;
                    end
                    READ:
                    begin
                        rd_active <= 1'b1;
                        wr_active <= 1'b0;
                        cur_bank  <= i_bus.ba;
                        cur_col   <= i_bus.addr[COL_W-1:0];
                        rd_wait   <= CAS_LAT - 2;   // first word driven two edges on
                    end
                    BST, PRE:
                    begin
                        wr_active <= 1'b0;
                        rd_active <= 1'b0;
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

endmodule

/* sdram_pkg.sv */
// sdram controller shared definitions
// device geometry, timing in clock cycles, pin command encodings
// and the packed structs passed between the blocks

package sdram_pkg;

    // geometry ----------------------------------
    localparam int ROW_W  = 13;
    localparam int COL_W  = 9;
    localparam int BANK_W = 2;
    localparam int DATA_W = 16;
    localparam int LEN_W  = COL_W + 1;   // up to a full page of 512

    // timing, in cycles -------------------------
    localparam int CAS_LAT          = 3;
    localparam int T_RP             = 3;
    localparam int T_RCD            = 3;
    localparam int T_RC             = 9;
    localparam int T_MRD            = 2;
    localparam int POWERUP_CYCLES   = 100;  // short power-up wait for simulation
    localparam int REFRESH_INTERVAL = 976;  // 64 ms / 8192 rows at 8 ns

    localparam int WAIT_W    = $clog2(POWERUP_CYCLES);   // longest wait in any fsm
    localparam int REF_CNT_W = $clog2(REFRESH_INTERVAL);

    // burst length full page, sequential, cas latency 3, programmed write burst
    localparam logic [ROW_W-1:0] MODE_WORD =
        {3'b000, 1'b0, 2'b00, 3'(CAS_LAT), 1'b0, 3'b111};

    localparam logic [ROW_W-1:0] PRE_ALL_ADDR = 13'h0400;  // a10 set, all banks

    // cs ras cas we, all active low
    typedef enum logic [3:0] {
        DESL  = 4'b1111,
        NOP   = 4'b0111,
        BST   = 4'b0110,
        READ  = 4'b0101,
        WRITE = 4'b0100,
        ACT   = 4'b0011,
        PRE   = 4'b0010,
        REF   = 4'b0001,
        MRS   = 4'b0000
    } sdram_cmd_e;

    typedef logic [DATA_W-1:0] data_t;

    typedef struct packed {
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
    } sdram_addr_t;

    typedef struct packed {
        sdram_addr_t      addr;
        logic [LEN_W-1:0] len;   // 0 behaves as 1
    } mem_req_t;

    typedef struct packed {
        sdram_cmd_e        cmd;
        logic [BANK_W-1:0] ba;
        logic [ROW_W-1:0]  addr;
        data_t             dq;
        logic              dq_oe;   // drive dq toward the device
    } sdram_bus_t;

    localparam sdram_bus_t BUS_NOP = '{
        cmd:   NOP,
        ba:    '0,
        addr:  '0,
        dq:    '0,
        dq_oe: 1'b0
    };

endpackage

/* sdram_refresh_timer.sv */
// sdram refresh timer
// raises a refresh request every REFRESH_INTERVAL cycles once enabled,
// the request is held until the access fsm acknowledges it

`timescale 1ns/10ps

module sdram_refresh_timer (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_enable,
    input  logic i_ref_ack,
    output logic o_ref_req
);
    import sdram_pkg::*;

    logic [REF_CNT_W-1:0] ref_cnt;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            ref_cnt   <= '0;
            o_ref_req <= 1'b0;
        end
        else
        begin
            if (i_ref_ack)
                o_ref_req <= 1'b0;

            // a new interval expiring wins over a late ack
            if (i_enable)
            begin
                if (ref_cnt == REF_CNT_W'(REFRESH_INTERVAL - 1))
                begin
                    ref_cnt   <= '0;
                    o_ref_req <= 1'b1;
                end
                else
                begin
                    ref_cnt <= ref_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* tb_sdram_ctrl.sv */
// testbench for the sdram controller
// table-driven bursts against a behavioural sdram plus init and refresh checks

`timescale 1ns/10ps

module tb_sdram_ctrl;
    import sdram_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 13;

    // cas 3 in a6..a4, sequential, full page burst in a2..a0
    localparam logic [ROW_W-1:0] EXP_MODE = 13'h037;

    typedef enum int {OP_INIT, OP_WR, OP_RD, OP_IDLE, OP_REF_RD} op_e;

    typedef struct {
        op_e op;
        int  bank;
        int  row;
        int  col;
        int  len;   // window length in cycles for OP_IDLE
    } entry_t;

    entry_t tests [NUM_TESTS] = '{
        '{OP_INIT,   0,    0,   0,   0},
        '{OP_WR,     0,    5,   0,  16},
        '{OP_RD,     0,    5,   0,  16},
        '{OP_WR,     1,  100,  37,   1},
        '{OP_RD,     1,  100,  37,   1},
        '{OP_WR,     2, 8191,   0, 512},
        '{OP_RD,     2, 8191,   0, 512},
        '{OP_WR,     3,   42, 500,   0},   // zero length acts as one word
        '{OP_RD,     3,   42, 500,   0},
        '{OP_WR,     1,    7, 200,  64},
        '{OP_RD,     1,    7, 210,  20},
        '{OP_IDLE,   0,    0,   0, 10 * REFRESH_INTERVAL},
        '{OP_REF_RD, 0,    5,   4,   8}
    };

    logic       clk = 1'b0;
    logic       rst;
    mem_req_t   req;
    logic       rd_strobe;
    logic       wr_strobe;
    logic       ready;
    logic       wr_data_req;
    data_t      wr_data;
    logic       rd_valid;
    data_t      rd_data;
    sdram_bus_t bus;
    data_t      dq;

    sdram_cmd_e       cmd_log [$];    // non-nop commands seen on the pins
    logic [ROW_W-1:0] addr_log [$];
    data_t            wr_words [$];
    data_t            rd_expect [$];
    data_t            ref_mem [logic [23:0]];
    logic [31:0]      rng = 32'd80987;
    int               ref_count = 0;
    int               wr_cycles = 0;
    int               rd_cycles = 0;
    int               err_total = 0;
    int               err_test = 0;
    int               tests_failed = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    sdram_ctrl dut0 (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_req         (req),
        .i_rd_strobe   (rd_strobe),
        .i_wr_strobe   (wr_strobe),
        .o_ready       (ready),
        .o_wr_data_req (wr_data_req),
        .i_wr_data     (wr_data),
        .o_rd_valid    (rd_valid),
        .o_rd_data     (rd_data),
        .o_bus         (bus),
        .i_dq          (dq)
    );

    sdram_model mem0 (
        .i_clk (clk),
        .i_rst (rst),
        .i_bus (bus),
        .o_dq  (dq)
    );

    bind sdram_ctrl sdram_ctrl_checker u_checker (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_bus         (o_bus),
        .i_ready       (o_ready),
        .i_rd_valid    (o_rd_valid),
        .i_wr_data_req (o_wr_data_req)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [23:0] word_key(input sdram_addr_t a, input int n);
        logic [COL_W-1:0] c;
        c = a.col + COL_W'(n);   // columns wrap inside the row
        return {a.bank, a.row, c};
    endfunction

    // compare tasks ----------------------------
    task automatic count_error();
        err_total++;
        err_test++;
    endtask

    task automatic report_failure(input string what);
        $display("failure at %0t: %s", $time, what);
        count_error();
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            count_error();
        end
    endtask

    task automatic check_cmd(input string name, input sdram_cmd_e got, input sdram_cmd_e exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
            count_error();
        end
    endtask

    task automatic check_count(input string name, input int got, input int lo, input int hi);
        if (got < lo || got > hi)
        begin
            if (lo == hi)
                $display("error at %0t: %s got %0d expected %0d", $time, name, got, lo);
            else
                $display("error at %0t: %s got %0d expected %0d to %0d", $time, name, got, lo, hi);
            count_error();
        end
    endtask

    // steps one clock and samples at the falling edge
    task automatic advance_cycle();
        @(negedge clk);
        if (bus.cmd != NOP)
        begin
            cmd_log.push_back(bus.cmd);
            addr_log.push_back(bus.addr);
        end
        if (bus.cmd == REF)
            ref_count++;
        if (wr_data_req)
        begin
            wr_cycles++;
            if (wr_words.size() > 0)
                wr_data = wr_words.pop_front();
        end
        if (rd_valid)
        begin
            rd_cycles++;
            if (rd_expect.size() > 0)
                check_data("o_rd_data", rd_data, rd_expect.pop_front());
            else
                report_failure("o_rd_valid high with no word left to read");
        end
    endtask

    task automatic check_init();
        int n;
        n = 0;
        while (!ready && n < POWERUP_CYCLES + 60)
        begin
            advance_cycle();
            n++;
        end
        if (!ready)
            report_failure("o_ready never rose after initialisation");
        check_count("init commands before o_ready", cmd_log.size(), 4, 4);
        if (cmd_log.size() == 4)
        begin
            check_cmd("init command 0", cmd_log[0], PRE);
            check_cmd("init command 1", cmd_log[1], REF);
            check_cmd("init command 2", cmd_log[2], REF);
            check_cmd("init command 3", cmd_log[3], MRS);
            check_count("a10 at init precharge", int'(addr_log[0][10]), 1, 1);
            check_count("mode word", int'(addr_log[3]), int'(EXP_MODE), int'(EXP_MODE));
        end
        cmd_log.delete();
        addr_log.delete();
    endtask

    task automatic run_access(input bit is_rd, input sdram_addr_t a, input int len);
        int          eff;
        int          n;
        bit          taken;
        logic [23:0] key;
        mem_req_t    r;
        eff    = (len == 0) ? 1 : len;
        r.addr = a;
        r.len  = LEN_W'(len);
        wr_words.delete();
        rd_expect.delete();
        for (n = 0; n < eff; n++)
        begin
            key = word_key(a, n);
            if (is_rd)
            begin
                rd_expect.push_back(ref_mem[key]);
            end
            else
            begin
                rng = xorshift32(rng);
                wr_words.push_back(rng[DATA_W-1:0]);
                ref_mem[key] = rng[DATA_W-1:0];
            end
        end
        wr_cycles = 0;
        rd_cycles = 0;
        taken     = 1'b0;
        n         = 0;
        // a pending refresh swallows the strobe so retry when idle
        while (!taken && n < REFRESH_INTERVAL + 100)
        begin
            if (ready)
            begin
                req       = r;
                rd_strobe = is_rd;
                wr_strobe = !is_rd;
                advance_cycle();
                rd_strobe = 1'b0;
                wr_strobe = 1'b0;
                taken     = (bus.cmd == ACT);
            end
            else
            begin
                advance_cycle();
            end
            n++;
        end
        if (!taken)
        begin
            report_failure("request was never accepted");
            return;
        end
        cmd_log.delete();
        addr_log.delete();
        n = 0;
        while (!ready && n < eff + 40)
        begin
            advance_cycle();
            n++;
        end
        if (!ready)
            report_failure("burst did not return to idle");
        if (is_rd)
            check_count("o_rd_valid cycles", rd_cycles, eff, eff);
        else
            check_count("o_wr_data_req cycles", wr_cycles, eff, eff);
        check_count("commands after activate", cmd_log.size(), 3, 3);
        if (cmd_log.size() == 3)
        begin
            check_cmd("burst command", cmd_log[0], is_rd ? READ : WRITE);
            check_cmd("command after burst", cmd_log[1], BST);
            check_cmd("command after bst", cmd_log[2], PRE);
            check_count("a10 at precharge", int'(addr_log[2][10]), 1, 1);
        end
        if (!is_rd)
        begin
            for (n = 0; n < eff; n++)
            begin
                key = word_key(a, n);
                check_data("model memory", mem0.mem[key], ref_mem[key]);
            end
        end
    endtask

    task automatic run_entry(input entry_t e);
        sdram_addr_t a;
        int          n;
        int          ref_before;
        a.bank = BANK_W'(e.bank);
        a.row  = ROW_W'(e.row);
        a.col  = COL_W'(e.col);
        case (e.op)
            OP_INIT:
                check_init();
            OP_WR:
                run_access(1'b0, a, e.len);
            OP_RD:
                run_access(1'b1, a, e.len);
            OP_IDLE:
            begin
                ref_before = ref_count;
                repeat (e.len) advance_cycle();
                check_count("REF commands in idle window", ref_count - ref_before, 9, 11);
            end
            OP_REF_RD:
            begin
                n = 0;
                while (!(ready && dut0.ref_req) && n < REFRESH_INTERVAL + 40)
                begin
                    advance_cycle();
                    n++;
                end
                if (!(ready && dut0.ref_req))
                begin
                    report_failure("no refresh became pending while idle");
                end
                else
                begin
                    ref_before = ref_count;
                    req.addr   = a;
                    req.len    = LEN_W'(e.len);
                    rd_strobe  = 1'b1;
                    advance_cycle();
                    rd_strobe  = 1'b0;
                    check_cmd("command after strobe with refresh pending", bus.cmd, PRE);
                    run_access(1'b1, a, e.len);
                    check_count("REF before read accepted", ref_count - ref_before, 1, 1);
                end
            end
            default:
                report_failure("unknown table entry");
        endcase
    endtask

    // main sequence ----------------------------
    initial
    begin
        rst       = 1'b1;
        req       = '0;
        rd_strobe = 1'b0;
        wr_strobe = 1'b0;
        wr_data   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < NUM_TESTS; i++)
        begin
            err_test = 0;
            run_entry(tests[i]);
            $display("test %0d %s bank %0d row %0d col %0d len %0d: %s", i,
                     tests[i].op.name(), tests[i].bank, tests[i].row, tests[i].col,
                     tests[i].len, (err_test == 0) ? "ok" : "failed");
            if (err_test != 0)
                tests_failed++;
        end
        check_count("checker assertion failures", dut0.u_checker.fail_count, 0, 0);

        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, err_total);
        if (err_total == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // watchdog sized from the table
    initial
    begin
        longint wd_cycles;
        wd_cycles = RESET_CYCLES + POWERUP_CYCLES;
        foreach (tests[i])
            wd_cycles += tests[i].len + 40 + REFRESH_INTERVAL;
        #(wd_cycles * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", wd_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
